// File: src/led_color_pkg.sv
package led_color_pkg;

	// one word per LED, sent green first
	typedef logic [23:0] pixel_t;

	localparam int NUM_PIXELS = 8;

	typedef logic [2:0] pixel_idx_t;

	// byte order is green, red, blue
	localparam pixel_t COLOR_RED    = 24'h00FE00;
	localparam pixel_t COLOR_ORANGE = 24'hCDFE00;
	localparam pixel_t COLOR_YELLOW = 24'hFEFE00;
	localparam pixel_t COLOR_GREEN  = 24'hFE0000;
	localparam pixel_t COLOR_CYAN   = 24'hFE00FE;
	localparam pixel_t COLOR_BLUE   = 24'h0000FE;
	localparam pixel_t COLOR_PURPLE = 24'h00CCCC;
	localparam pixel_t COLOR_WHITE  = 24'hFEFEFE;
	localparam pixel_t COLOR_DIM    = 24'h1F1F1F; // low level on all three channels
	localparam pixel_t COLOR_OFF    = 24'h000000;

	localparam pixel_t RAINBOW [NUM_PIXELS] = '{
		COLOR_RED,
		COLOR_ORANGE,
		COLOR_YELLOW,
		COLOR_GREEN,
		COLOR_CYAN,
		COLOR_BLUE,
		COLOR_PURPLE,
		COLOR_WHITE
	};

endpackage

// File: src/led_cmd_pkg.sv
package led_cmd_pkg;

	// speed bits, fast wins over slow
	localparam int CMD_FAST_BIT  = 0;
	localparam int CMD_SLOW_BIT  = 1;

	// mode bits, shift wins over blink
	localparam int CMD_SHIFT_BIT = 2;
	localparam int CMD_BLINK_BIT = 3;

	// four one-hot pattern bits start here
	localparam int CMD_PATTERN_LSB = 4;

	typedef enum logic [2:0] {
		PAT_NONE,
		PAT_GREEN_CHASE,
		PAT_RAINBOW,
		PAT_RGBW_CHASE,
		PAT_DIM
	} pattern_t;

endpackage

// File: src/step_timer.sv
`timescale 1ns/1ns

module step_timer
	import led_color_pkg::*;
	import led_cmd_pkg::*;
#(
	parameter int STEP_FAST   = 5_000_000,
	parameter int STEP_NORMAL = 50_000_000,
	parameter int STEP_SLOW   = 150_000_000
) (
	input  logic       clk_RGB_Control,
	input  logic       rst_n,
	input  logic [7:0] uart_data,
	output pixel_idx_t step,
	output logic       shifting,
	output logic       lit
);

	localparam int MAX_FN = (STEP_FAST > STEP_NORMAL) ? STEP_FAST : STEP_NORMAL;
	localparam int MAX_P  = (STEP_SLOW > MAX_FN) ? STEP_SLOW : MAX_FN;
	localparam int CNT_W  = $clog2(MAX_P + 1);

	logic [CNT_W-1:0] period;
	logic [CNT_W-1:0] cnt;
	logic             shift_on;
	logic             blink_on;
	logic             wrap;

	assign shift_on = uart_data[CMD_SHIFT_BIT];
	assign blink_on = uart_data[CMD_BLINK_BIT] & ~shift_on; // shift has priority

	always_comb begin
		if (uart_data[CMD_FAST_BIT])
			period = CNT_W'(STEP_FAST);
		else if (uart_data[CMD_SLOW_BIT])
			period = CNT_W'(STEP_SLOW);
		else
			period = CNT_W'(STEP_NORMAL);
	end

	// >= so a speed change to a shorter period never overruns
	assign wrap = (cnt >= period - 1'b1);

	always_ff @(posedge clk_RGB_Control or negedge rst_n) begin
		if (!rst_n) begin
			cnt      <= '0;
			step     <= '0;
			shifting <= 1'b0;
			lit      <= 1'b1;
		end else begin
			shifting <= shift_on;
			if (shift_on) begin
				lit <= 1'b1;
				if (wrap) begin
					cnt  <= '0;
					step <= step + 1'b1; // wraps at 8
				end else begin
					cnt <= cnt + 1'b1;
				end
			end else if (blink_on) begin
				step <= '0;
				if (wrap) begin
					cnt <= '0;
					lit <= ~lit; // one period lit, one dark
				end else begin
					cnt <= cnt + 1'b1;
				end
			end else begin
				cnt  <= '0;
				step <= '0;
				lit  <= 1'b1;
			end
		end
	end

endmodule

// File: src/pattern_gen.sv
`timescale 1ns/1ns

module pattern_gen
	import led_color_pkg::*;
	import led_cmd_pkg::*;
(
	input  logic       clk_RGB_Control,
	input  logic       rst_n,
	input  logic [7:0] uart_data,
	input  pixel_idx_t step,
	input  logic       shifting,
	input  logic       lit,
	output pixel_t     frame [NUM_PIXELS]
);

	logic [3:0] pat_bits;
	pattern_t   pat;
	pixel_t     next_frame [NUM_PIXELS];

	// red, green, blue, white in turn
	function automatic pixel_t rgbw_color(input logic [1:0] sel);
		case (sel)
			2'd0: rgbw_color = COLOR_RED;
			2'd1: rgbw_color = COLOR_GREEN;
			2'd2: rgbw_color = COLOR_BLUE;
			default: rgbw_color = COLOR_WHITE;
		endcase
	endfunction

	assign pat_bits = uart_data[CMD_PATTERN_LSB +: 4];

	// lowest set bit wins
	always_comb begin
		if (pat_bits[0])
			pat = PAT_GREEN_CHASE;
		else if (pat_bits[1])
			pat = PAT_RAINBOW;
		else if (pat_bits[2])
			pat = PAT_RGBW_CHASE;
		else if (pat_bits[3])
			pat = PAT_DIM;
		else
			pat = PAT_NONE;
	end

	always_comb begin
		pixel_idx_t pos;
		pixel_idx_t rot;
		for (int i = 0; i < NUM_PIXELS; i++) begin
			pos = pixel_idx_t'(i);
			rot = pos - step; // mod 8 by width
			if (!lit || pat == PAT_NONE)
				next_frame[i] = COLOR_OFF;
			else if (pat == PAT_DIM)
				next_frame[i] = COLOR_DIM;
			else if (!shifting)
				next_frame[i] = RAINBOW[i]; // static picture
			else begin
				case (pat)
					PAT_GREEN_CHASE:
						next_frame[i] = (pos == step) ? COLOR_GREEN : COLOR_OFF;
					PAT_RAINBOW:
						next_frame[i] = RAINBOW[rot];
					PAT_RGBW_CHASE:
						next_frame[i] = (pos == step) ? rgbw_color(step[1:0]) : COLOR_OFF;
					default:
						next_frame[i] = COLOR_OFF;
				endcase
			end
		end
	end

	always_ff @(posedge clk_RGB_Control or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < NUM_PIXELS; i++)
				frame[i] <= COLOR_OFF;
		end else begin
			frame <= next_frame;
		end
	end

endmodule

// File: src/frame_streamer.sv
`timescale 1ns/1ns

module frame_streamer
	import led_color_pkg::*;
#(
	parameter int GAP_CYCLES = 15_000
) (
	input  logic   clk_RGB_Control,
	input  logic   rst_n,
	input  pixel_t frame [NUM_PIXELS],
	input  logic   tx_done,
	output logic   tx_en,
	output pixel_t rgb
);

	localparam int GAP_W = $clog2(GAP_CYCLES + 1);

	logic [GAP_W-1:0] gap_cnt;
	pixel_t           snap [NUM_PIXELS];
	pixel_idx_t       idx;
	logic             start;
	logic             last_done;

	// gap counter runs only while idle
	assign start     = ~tx_en && (gap_cnt == GAP_W'(GAP_CYCLES - 1));
	assign last_done = tx_en && tx_done && (idx == pixel_idx_t'(NUM_PIXELS - 1));

	always_ff @(posedge clk_RGB_Control or negedge rst_n) begin
		if (!rst_n) begin
			gap_cnt <= '0;
			tx_en   <= 1'b0;
			idx     <= '0;
			rgb     <= COLOR_OFF;
		end else if (!tx_en) begin
			if (start) begin
				gap_cnt <= '0;
				tx_en   <= 1'b1;
				idx     <= '0;
				rgb     <= frame[0]; // straight from the live frame
			end else begin
				gap_cnt <= gap_cnt + 1'b1;
			end
		end else if (tx_done) begin
			if (last_done) begin
				tx_en <= 1'b0; // latch gap starts here
				idx   <= '0;
				rgb   <= COLOR_OFF;
			end else begin
				idx <= idx + 1'b1;
				rgb <= snap[idx + 1'b1];
			end
		end
	end

	// frame held steady for the whole transfer
	always_ff @(posedge clk_RGB_Control) begin
		if (start)
			snap <= frame;
	end

endmodule

// File: src/rgb_led_ctrl.sv
`timescale 1ns/1ns

module rgb_led_ctrl
	import led_color_pkg::*;
#(
	parameter int STEP_FAST   = 5_000_000,   // 0.1 s at 50 MHz
	parameter int STEP_NORMAL = 50_000_000,  // 1 s
	parameter int STEP_SLOW   = 150_000_000, // 3 s
	parameter int GAP_CYCLES  = 15_000       // 300 us latch gap
) (
	input  logic       clk_RGB_Control,
	input  logic       rst_n,
	input  logic [7:0] uart_data,
	input  logic       tx_done,
	output logic       tx_en,
	output pixel_t     rgb
);

	pixel_idx_t step;
	logic       shifting;
	logic       lit;
	pixel_t     frame [NUM_PIXELS];

	step_timer #(
		.STEP_FAST   (STEP_FAST),
		.STEP_NORMAL (STEP_NORMAL),
		.STEP_SLOW   (STEP_SLOW)
	) step_timer_i (
		.clk_RGB_Control (clk_RGB_Control),
		.rst_n           (rst_n),
		.uart_data       (uart_data),
		.step            (step),
		.shifting        (shifting),
		.lit             (lit)
	);

	pattern_gen pattern_gen_i (
		.clk_RGB_Control (clk_RGB_Control),
		.rst_n           (rst_n),
		.uart_data       (uart_data),
		.step            (step),
		.shifting        (shifting),
		.lit             (lit),
		.frame           (frame)
	);

	frame_streamer #(
		.GAP_CYCLES (GAP_CYCLES)
	) frame_streamer_i (
		.clk_RGB_Control (clk_RGB_Control),
		.rst_n           (rst_n),
		.frame           (frame),
		.tx_done         (tx_done),
		.tx_en           (tx_en),
		.rgb             (rgb)
	);

endmodule

// File: sim/tb_rgb_led_ctrl.sv
`timescale 1ns/1ns

module tb_rgb_led_ctrl
	import led_color_pkg::*;
	import led_cmd_pkg::*;
();

	localparam int STEP_FAST   = 400;
	localparam int STEP_NORMAL = 800;
	localparam int STEP_SLOW   = 2000;
	localparam int GAP_CYCLES  = 20;
	localparam int FRAME_MAX   = GAP_CYCLES + NUM_PIXELS * 7; // longest frame plus slack

	localparam logic [7:0] FAST  = 8'(1 << CMD_FAST_BIT);
	localparam logic [7:0] SLOW  = 8'(1 << CMD_SLOW_BIT);
	localparam logic [7:0] SHIFT = 8'(1 << CMD_SHIFT_BIT);
	localparam logic [7:0] BLINK = 8'(1 << CMD_BLINK_BIT);

	// offsets of the pattern bits above CMD_PATTERN_LSB
	localparam int SEL_NONE    = -1;
	localparam int SEL_GREEN   = 0;
	localparam int SEL_RAINBOW = 1;
	localparam int SEL_RGBW    = 2;
	localparam int SEL_DIM     = 3;

	logic        clk_RGB_Control;
	logic        rst_n;
	logic [7:0]  uart_data;
	logic        tx_done;
	logic        tx_en;
	pixel_t      rgb;

	pixel_t      got [NUM_PIXELS];
	int unsigned cycles = 0;
	int unsigned frame_start;
	int          errors = 0;
	int          checks = 0;

	rgb_led_ctrl #(
		.STEP_FAST   (STEP_FAST),
		.STEP_NORMAL (STEP_NORMAL),
		.STEP_SLOW   (STEP_SLOW),
		.GAP_CYCLES  (GAP_CYCLES)
	) rgb_led_ctrl_i (
		.clk_RGB_Control (clk_RGB_Control),
		.rst_n           (rst_n),
		.uart_data       (uart_data),
		.tx_done         (tx_done),
		.tx_en           (tx_en),
		.rgb             (rgb)
	);

	initial begin
		clk_RGB_Control = 1'b0;
		forever #50 clk_RGB_Control = ~clk_RGB_Control;
	end

	always @(posedge clk_RGB_Control)
		cycles <= cycles + 1;

	task automatic tick();
		@(posedge clk_RGB_Control);
		#10; // drive and sample away from the edge
	endtask

	task automatic check_equal(input string name, input logic [31:0] got_v,
		input logic [31:0] exp_v);
		checks++;
		if (got_v !== exp_v) begin
			$display("Error: %s = %h, expected %h", name, got_v, exp_v);
			errors++;
		end
	endtask

	task automatic report_failure(input string msg);
		$display("%s", msg);
		errors++;
	endtask

	function automatic logic [7:0] make_cmd(input int sel, input logic [7:0] mode);
		if (sel < 0)
			return mode;
		return mode | 8'(1 << (CMD_PATTERN_LSB + sel));
	endfunction

	// pixel i of a shifting pattern at step s
	function automatic pixel_t expected_pixel(input int sel, input int s, input int i);
		pixel_idx_t rot;
		rot = pixel_idx_t'(i - s); // wraps mod 8
		if (sel == SEL_RAINBOW)
			return RAINBOW[rot];
		if (i != s)
			return COLOR_OFF;
		if (sel == SEL_GREEN)
			return COLOR_GREEN;
		case (s % 4)
			0: return COLOR_RED;
			1: return COLOR_GREEN;
			2: return COLOR_BLUE;
			default: return COLOR_WHITE;
		endcase
	endfunction

	function automatic int match_step(input int sel);
		int   found;
		logic same;
		found = -1;
		for (int s = 0; s < NUM_PIXELS; s++) begin
			same = 1'b1;
			for (int i = 0; i < NUM_PIXELS; i++)
				if (got[i] != expected_pixel(sel, s, i))
					same = 1'b0;
			if (same && found < 0)
				found = s;
		end
		return found;
	endfunction

	function automatic logic frame_dark();
		frame_dark = 1'b1;
		for (int i = 0; i < NUM_PIXELS; i++)
			if (got[i] != COLOR_OFF)
				frame_dark = 1'b0;
	endfunction

	task automatic wait_tx_en(input logic level, input int limit, output int n);
		n = 0;
		while (tx_en !== level && n < limit) begin
			tick();
			n++;
		end
		if (tx_en !== level)
			report_failure($sformatf("tx_en did not reach %0b within %0d cycles", level, limit));
	endtask

	// encoder model for one word, rgb must hold until the done pulse
	task automatic send_word(input int w, input int delay);
		pixel_t held;
		held = rgb;
		for (int d = 0; d < delay; d++) begin
			tick();
			check_equal("rgb", 32'(rgb), 32'(held));
			check_equal("tx_en", 32'(tx_en), 32'd1);
		end
		tx_done = 1'b1;
		got[w] = rgb;
		tick();
		tx_done = 1'b0;
	endtask

	task automatic capture_frame(input int slow_word);
		int n;
		wait_tx_en(1'b1, 2 * GAP_CYCLES + 10, n);
		frame_start = cycles;
		for (int w = 0; w < NUM_PIXELS; w++)
			send_word(w, (w == slow_word) ? 30 : 2 + int'($urandom % 4));
		check_equal("tx_en", 32'(tx_en), 32'd0); // frame over after eight words
	endtask

	task automatic test_reset_and_gap();
		int n;
		rst_n = 1'b0;
		for (int c = 0; c < 2; c++) begin
			tick();
			check_equal("tx_en", 32'(tx_en), 32'd0);
			check_equal("rgb", 32'(rgb), 32'd0);
		end
		rst_n = 1'b1;
		wait_tx_en(1'b1, 2 * GAP_CYCLES, n);
		check_equal("gap after reset", 32'(n), 32'(GAP_CYCLES));
		for (int f = 0; f < 2; f++) begin
			capture_frame(-1);
			wait_tx_en(1'b1, 2 * GAP_CYCLES, n);
			check_equal("gap after frame", 32'(n), 32'(GAP_CYCLES));
		end
	endtask

	task automatic test_still(input int sel, input pixel_t fill);
		uart_data = make_cmd(sel, 8'd0);
		capture_frame(-1); // lets the new command settle
		for (int f = 0; f < 2; f++) begin
			capture_frame(-1);
			for (int i = 0; i < NUM_PIXELS; i++)
				check_equal($sformatf("rgb[%0d]", i), 32'(got[i]),
					32'((sel == SEL_RAINBOW) ? RAINBOW[i] : fill));
		end
	endtask

	task automatic test_shift(input int sel);
		int prev_s;
		int s;
		int changes;
		uart_data = make_cmd(sel, SHIFT | FAST);
		capture_frame(-1);
		capture_frame(-1);
		prev_s = match_step(sel);
		changes = 0;
		for (int f = 0; f < 50 && changes < 3; f++) begin
			capture_frame(-1);
			s = match_step(sel);
			if (s < 0) begin
				report_failure($sformatf("frame of pattern %0d matches no step", sel));
			end else if (s != prev_s) begin
				check_equal("step", 32'(s), 32'((prev_s + 1) % NUM_PIXELS));
				changes++;
				prev_s = s;
			end
		end
		if (changes < 3)
			report_failure($sformatf("pattern %0d did not advance three steps", sel));
	endtask

	task automatic test_blink();
		logic kind;
		logic prev_kind;
		int   lit_frames;
		int   dark_frames;
		int   changes;
		uart_data = make_cmd(SEL_RAINBOW, BLINK | FAST);
		capture_frame(-1);
		prev_kind = 1'b1;
		lit_frames = 0;
		dark_frames = 0;
		changes = 0;
		for (int f = 0; f < 36; f++) begin
			capture_frame(-1);
			if (match_step(SEL_RAINBOW) == 0) begin
				kind = 1'b1;
			end else if (frame_dark()) begin
				kind = 1'b0;
			end else begin
				report_failure("blink frame is neither the rainbow nor dark");
				kind = prev_kind;
			end
			if (f > 0 && kind != prev_kind)
				changes++;
			if (kind)
				lit_frames++;
			else
				dark_frames++;
			prev_kind = kind;
		end
		if (lit_frames == 0 || dark_frames == 0 || changes < 2)
			report_failure("blink did not alternate between lit and dark frames");
	endtask

	task automatic measure_period(input logic [7:0] speed, input int period, input string name);
		int          prev_s;
		int          s;
		int          changes;
		int          limit;
		int          diff;
		int          near;
		int unsigned t_first;
		uart_data = make_cmd(SEL_GREEN, SHIFT | speed);
		capture_frame(-1);
		prev_s = match_step(SEL_GREEN);
		changes = 0;
		limit = 3 * period / 40 + 10;
		t_first = 0;
		while (changes < 2 && limit > 0) begin
			capture_frame(-1);
			s = match_step(SEL_GREEN);
			limit--;
			if (s != prev_s) begin
				changes++;
				if (changes == 1) begin
					t_first = frame_start;
				end else begin
					diff = int'(frame_start - t_first);
					// detection is only as fine as one frame
					near = (diff >= period - FRAME_MAX && diff <= period + FRAME_MAX) ?
						period : diff;
					check_equal(name, 32'(near), 32'(period));
				end
				prev_s = s;
			end
		end
		if (changes < 2)
			report_failure($sformatf("%s: two step changes not seen in time", name));
	endtask

	task automatic test_backpressure();
		uart_data = make_cmd(SEL_RAINBOW, 8'd0);
		capture_frame(-1);
		capture_frame(3); // encoder stalls on the fourth word
		for (int i = 0; i < NUM_PIXELS; i++)
			check_equal($sformatf("rgb[%0d]", i), 32'(got[i]), 32'(RAINBOW[i]));
	endtask

	initial begin
		void'($urandom(46972));
		rst_n     = 1'b0;
		uart_data = 8'd0;
		tx_done   = 1'b0;

		test_reset_and_gap();
		test_still(SEL_RAINBOW, COLOR_OFF);
		test_still(SEL_DIM, COLOR_DIM);
		test_still(SEL_NONE, COLOR_OFF);
		test_shift(SEL_GREEN);
		test_shift(SEL_RAINBOW);
		test_shift(SEL_RGBW);
		test_blink();
		measure_period(FAST, STEP_FAST, "fast step period");
		measure_period(8'd0, STEP_NORMAL, "normal step period");
		measure_period(SLOW, STEP_SLOW, "slow step period");
		test_backpressure();

		$display("Checks: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("All tests passed");
		else
			$display("Some tests failed");
		$finish;
	end

endmodule

// File: tb.f
src/led_color_pkg.sv
src/led_cmd_pkg.sv
src/step_timer.sv
src/pattern_gen.sv
src/frame_streamer.sv
src/rgb_led_ctrl.sv
sim/tb_rgb_led_ctrl.sv

// File: Makefile
TOP = tb_rgb_led_ctrl

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing -f tb.f --top-module $(TOP) -o $(TOP)

run: compile
	@out="$$(./obj_dir/$(TOP))"; echo "$$out"; echo "$$out" | grep -q "All tests passed"

clean:
	rm -rf obj_dir
